// File: hdl/victim_cache_macros.svh
`ifndef VICTIM_CACHE_MACROS_SVH
`define VICTIM_CACHE_MACROS_SVH

// number of fully associative slots, tied to the 8-bit LRU order
`define VC_WAYS 4

// one whole L1/L2 line
`define VC_LINE_BITS 128

`define VC_TAG_BITS 12 // upper address bits of a line

// zero low bits appended to a tag to make an L2 address
`define VC_OFFSET_BITS 4

`endif

// File: hdl/lc3b_types.sv
`include "victim_cache_macros.svh"

package lc3b_types;

	typedef logic [`VC_LINE_BITS-1:0] lc3b_cache_line;
	typedef logic [`VC_TAG_BITS-1:0] lc3b_v_tag;
	typedef logic [`VC_TAG_BITS+`VC_OFFSET_BITS-1:0] lc3b_word;
	typedef logic [$clog2(`VC_WAYS)-1:0] lc3b_way;

	typedef enum logic {
		VC_FETCH,
		VC_SWAP // fetch plus an evicted L1 line
	} vc_op_e;

	typedef struct packed {
		vc_op_e op;
		lc3b_v_tag tag; // line L1 is missing
		lc3b_v_tag evict_tag;
		lc3b_cache_line evict_line;
		logic evict_dirty;
	} vc_l1_req_t;

	typedef struct packed {
		logic dirty;
		lc3b_cache_line line;
	} vc_l1_resp_t;

	typedef struct packed {
		logic write;
		lc3b_word address;
		lc3b_cache_line wdata;
	} vc_l2_req_t;

	typedef enum logic [2:0] {
		IDLE,
		LOOKUP,
		WRITEBACK,
		READ_L2,
		INSTALL,
		RESPOND
	} vc_state_e;

endpackage : lc3b_types

// File: hdl/cache_slot.sv
`timescale 1ns/100ps

module cache_slot (
	input logic clk,
	input logic arst_n,
	input logic write,
	input logic dirty_in,
	input logic valid_in,
	input lc3b_types::lc3b_v_tag tag_in,
	input lc3b_types::lc3b_v_tag tag_cmp,
	input lc3b_types::lc3b_cache_line wdata,
	output lc3b_types::lc3b_cache_line line,
	output lc3b_types::lc3b_v_tag tag,
	output logic hit,
	output logic valid,
	output logic dirty
);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid <= 1'b0;
		end else if (write) begin
			valid <= valid_in; // a write with valid_in low frees the slot
		end
	end

	always_ff @(posedge clk) begin
		if (write) begin
			line <= wdata;
			tag <= tag_in;
			dirty <= dirty_in;
		end
	end

	// an invalid slot never matches, whatever its stale tag holds
	assign hit = valid && (tag == tag_cmp);

endmodule : cache_slot

// File: hdl/victim_fill_stage.sv
`timescale 1ns/100ps
`include "victim_cache_macros.svh"

module victim_fill_stage (
	input logic clk,
	input logic arst_n,
	input logic in_load,
	input logic slot_write,
	input lc3b_types::vc_l1_req_t req,
	input lc3b_types::lc3b_way way_sel,
	output lc3b_types::vc_l1_req_t held_req,
	output logic [`VC_WAYS-1:0] slot_en
);

	// the L1 holds its request only until l1_ack, so keep a private copy
	// for the slot compare, the L2 address and the install
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			held_req <= '0;
		end else if (in_load) begin
			held_req <= req;
		end
	end

	always_comb begin
		slot_en = '0;
		if (slot_write) begin
			slot_en[way_sel] = 1'b1; // one-hot, at most one slot per install
		end
	end

endmodule : victim_fill_stage

// File: hdl/victim_drain_stage.sv
`timescale 1ns/100ps
`include "victim_cache_macros.svh"

module victim_drain_stage (
	input logic clk,
	input logic arst_n,
	input logic out_load,
	input logic l1_src,
	input lc3b_types::lc3b_cache_line slot_line [`VC_WAYS],
	input lc3b_types::lc3b_v_tag slot_tag [`VC_WAYS],
	input logic [`VC_WAYS-1:0] slot_valid,
	input logic [`VC_WAYS-1:0] slot_dirty,
	input logic [`VC_WAYS-1:0] slot_hit,
	input lc3b_types::lc3b_way lru_way,
	input lc3b_types::lc3b_cache_line l2_rdata,
	output logic hit,
	output logic victim_valid,
	output logic victim_dirty,
	output lc3b_types::lc3b_way hit_way,
	output lc3b_types::lc3b_v_tag victim_tag,
	output lc3b_types::vc_l1_resp_t out_line,
	output lc3b_types::vc_l1_resp_t l1_resp
);
	import lc3b_types::*;

	lc3b_way sel_way;
	vc_l1_resp_t out_d;

	// tags are unique across slots, so at most one hit bit is set
	always_comb begin
		hit_way = '0;
		for (int w = 0; w < `VC_WAYS; w++) begin
			if (slot_hit[w]) begin
				hit_way = lc3b_way'(w);
			end
		end
	end

	assign hit = |slot_hit;
	assign sel_way = hit ? hit_way : lru_way;

	assign victim_valid = slot_valid[sel_way];
	assign victim_dirty = slot_dirty[sel_way];
	assign victim_tag = slot_tag[sel_way];

	// L2 data only lasts while l2_ack is high, so it is captured here too
	assign out_d = l1_src ? {1'b0, l2_rdata} : {slot_dirty[sel_way], slot_line[sel_way]};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_line <= '0;
		end else if (out_load) begin
			out_line <= out_d;
		end
	end

	assign l1_resp = out_line; // write-back data until L2 read data replaces it

endmodule : victim_drain_stage

// File: hdl/victim_lru.sv
`timescale 1ns/100ps
`include "victim_cache_macros.svh"

module victim_lru (
	input logic clk,
	input logic arst_n,
	input logic touch,
	input lc3b_types::lc3b_way touch_way,
	output lc3b_types::lc3b_way lru_way
);

	// four 2-bit way numbers, bits [1:0] hold the least recent way
	logic [7:0] order;
	logic [7:0] order_next;
	logic [2:0] keep;

	always_comb begin
		order_next = order;
		keep = '0;
		// slide the other three ways down, keeping their relative age
		for (int i = 0; i < `VC_WAYS; i++) begin
			if (order[2*i +: 2] != touch_way) begin
				order_next[2*keep +: 2] = order[2*i +: 2];
				keep = keep + 3'd1;
			end
		end
		order_next[7:6] = touch_way; // most recent sits on top
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			order <= {2'd3, 2'd2, 2'd1, 2'd0};
		end else if (touch) begin
			order <= order_next;
		end
	end

	assign lru_way = order[1:0];

endmodule : victim_lru

// File: hdl/victim_cache_control.sv
`timescale 1ns/100ps
`include "victim_cache_macros.svh"

module victim_cache_control (
	input logic clk,
	input logic arst_n,
	input logic l1_req,
	output logic l1_ack,
	input lc3b_types::vc_l1_req_t held_req,
	input logic hit,
	input logic victim_valid,
	input logic victim_dirty,
	input lc3b_types::lc3b_way hit_way,
	input lc3b_types::lc3b_way lru_way,
	input lc3b_types::lc3b_v_tag victim_tag,
	input lc3b_types::vc_l1_resp_t out_line,
	output logic l2_req,
	input logic l2_ack,
	output lc3b_types::vc_l2_req_t l2_req_data,
	output logic in_load,
	output logic slot_write,
	output logic out_load,
	output logic l1_src,
	output logic lru_touch,
	output lc3b_types::lc3b_way way_sel
);
	import lc3b_types::*;

	vc_state_e state;
	logic l2_done; // L2 has acked, now waiting for its ack to fall
	logic l2_xfer;
	logic hit_q;
	lc3b_way way_q;

	assign l2_xfer = l2_req && l2_ack;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= IDLE;
			l1_ack <= 1'b0;
			l2_req <= 1'b0;
			l2_done <= 1'b0;
			hit_q <= 1'b0;
			way_q <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (l1_req) begin
						state <= LOOKUP;
					end
				end
				LOOKUP: begin
					// the way is decided once here and held through INSTALL
					hit_q <= hit;
					way_q <= hit ? hit_way : lru_way;
					if (hit) begin
						state <= INSTALL;
					end else if (held_req.op == VC_SWAP && victim_valid && victim_dirty) begin
						state <= WRITEBACK;
					end else begin
						state <= READ_L2;
					end
				end
				WRITEBACK, READ_L2: begin
					if (l2_xfer) begin
						l2_req <= 1'b0;
						l2_done <= 1'b1;
					end else if (!l2_done) begin
						l2_req <= 1'b1;
					end else if (!l2_ack) begin
						l2_done <= 1'b0;
						state <= (state == WRITEBACK) ? READ_L2 : INSTALL;
					end
				end
				INSTALL: begin
					state <= RESPOND;
				end
				RESPOND: begin
					// ack rises one cycle into RESPOND and follows l1_req down
					l1_ack <= l1_req;
					if (l1_ack && !l1_req) begin
						state <= IDLE;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	assign in_load = (state == IDLE) && l1_req;
	assign out_load = (state == LOOKUP) || ((state == READ_L2) && l2_xfer);
	assign l1_src = (state == READ_L2);

	// a fetch miss leaves the slots alone, a fetch hit frees its slot
	assign slot_write = (state == INSTALL) && (hit_q || held_req.op == VC_SWAP);
	assign lru_touch = slot_write;
	assign way_sel = way_q;

	// slots and LRU are frozen until INSTALL, so these stay put while l2_req is high
	always_comb begin
		l2_req_data.write = (state == WRITEBACK);
		l2_req_data.address = {(state == WRITEBACK) ? victim_tag : held_req.tag,
			{`VC_OFFSET_BITS{1'b0}}};
		l2_req_data.wdata = out_line.line;
	end

endmodule : victim_cache_control

// File: hdl/victim_cache.sv
`timescale 1ns/100ps
`include "victim_cache_macros.svh"

module victim_cache (
	input logic clk,
	input logic arst_n,
	input logic l1_req,
	input lc3b_types::vc_l1_req_t l1_req_data,
	output logic l1_ack,
	output lc3b_types::vc_l1_resp_t l1_resp,
	output logic l2_req,
	output lc3b_types::vc_l2_req_t l2_req_data,
	input logic l2_ack,
	input lc3b_types::lc3b_cache_line l2_rdata
);
	import lc3b_types::*;

	vc_l1_req_t held_req;
	vc_l1_resp_t out_line;
	logic [`VC_WAYS-1:0] slot_en;
	lc3b_cache_line slot_line [`VC_WAYS];
	lc3b_v_tag slot_tag [`VC_WAYS];
	logic [`VC_WAYS-1:0] slot_valid;
	logic [`VC_WAYS-1:0] slot_dirty;
	logic [`VC_WAYS-1:0] slot_hit;
	logic hit;
	logic victim_valid;
	logic victim_dirty;
	lc3b_way hit_way;
	lc3b_way lru_way;
	lc3b_way way_sel;
	lc3b_v_tag victim_tag;
	logic in_load;
	logic slot_write;
	logic out_load;
	logic l1_src;
	logic lru_touch;

	victim_cache_control control (
		.clk,
		.arst_n,
		.l1_req,
		.l1_ack,
		.held_req,
		.hit,
		.victim_valid,
		.victim_dirty,
		.hit_way,
		.lru_way,
		.victim_tag,
		.out_line,
		.l2_req,
		.l2_ack,
		.l2_req_data,
		.in_load,
		.slot_write,
		.out_load,
		.l1_src,
		.lru_touch,
		.way_sel
	);

	victim_fill_stage fill (
		.clk,
		.arst_n,
		.in_load,
		.slot_write,
		.req(l1_req_data),
		.way_sel,
		.held_req,
		.slot_en
	);

	for (genvar w = 0; w < `VC_WAYS; w++) begin : g_slot
		cache_slot slot (
			.clk,
			.arst_n,
			.write(slot_en[w]),
			.dirty_in(held_req.evict_dirty),
			.valid_in(held_req.op == VC_SWAP), // fetch hits clear the slot
			.tag_in(held_req.evict_tag),
			.tag_cmp(held_req.tag),
			.wdata(held_req.evict_line),
			.line(slot_line[w]),
			.tag(slot_tag[w]),
			.hit(slot_hit[w]),
			.valid(slot_valid[w]),
			.dirty(slot_dirty[w])
		);
	end

	victim_drain_stage drain (
		.clk,
		.arst_n,
		.out_load,
		.l1_src,
		.slot_line,
		.slot_tag,
		.slot_valid,
		.slot_dirty,
		.slot_hit,
		.lru_way,
		.l2_rdata,
		.hit,
		.victim_valid,
		.victim_dirty,
		.hit_way,
		.victim_tag,
		.out_line,
		.l1_resp
	);

	victim_lru lru (
		.clk,
		.arst_n,
		.touch(lru_touch),
		.touch_way(way_sel),
		.lru_way
	);

endmodule : victim_cache

// File: tb/l2_memory_model.sv
`timescale 1ns/100ps
`include "victim_cache_macros.svh"

module l2_memory_model (
	input logic clk,
	input logic arst_n,
	input logic req,
	input lc3b_types::vc_l2_req_t req_data,
	output logic ack,
	output lc3b_types::lc3b_cache_line rdata
);
	import lc3b_types::*;

	lc3b_cache_line mem [0:(1<<`VC_TAG_BITS)-1];
	lc3b_v_tag line_idx;
	integer seed = 32'hce0ef2b2;
	int delay; // idle cycles before the next ack
	// every transaction in issue order, read by the testbench
	int log_count;
	logic log_write [0:511];
	lc3b_word log_addr [0:511];
	lc3b_cache_line log_wdata [0:511];

	function automatic lc3b_cache_line initial_line(input lc3b_word addr);
		return {addr, ~addr, addr ^ 16'h5a5a, addr + 16'h1357,
			{addr[7:0], addr[15:8]}, addr - 16'h2468, ~addr ^ 16'h0f0f, addr ^ 16'hc3c3};
	endfunction

	initial begin
		for (int t = 0; t < (1 << `VC_TAG_BITS); t++) begin
			mem[t] = initial_line({lc3b_v_tag'(t), {`VC_OFFSET_BITS{1'b0}}});
		end
	end

	assign line_idx = req_data.address[`VC_TAG_BITS+`VC_OFFSET_BITS-1:`VC_OFFSET_BITS];

	always @(negedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ack <= 1'b0;
			rdata <= '0;
			delay <= 2;
			log_count <= 0;
		end else if (ack) begin
			if (!req) begin
				ack <= 1'b0; // return to zero once the cache lets go
			end
		end else if (req && delay > 0) begin
			delay <= delay - 1;
		end else if (req) begin
			ack <= 1'b1;
			delay <= {$random(seed)} % 4;
			if (req_data.write) begin
				mem[line_idx] <= req_data.wdata;
			end else begin
				rdata <= mem[line_idx];
			end
			log_write[log_count] <= req_data.write;
			log_addr[log_count] <= req_data.address;
			log_wdata[log_count] <= req_data.wdata;
			log_count <= log_count + 1;
		end
	end

endmodule : l2_memory_model

// File: tb/victim_cache_tb.sv
`timescale 1ns/100ps
`include "victim_cache_macros.svh"

module victim_cache_tb;
	import lc3b_types::*;

	logic clk;
	logic arst_n;
	logic l1_req;
	vc_l1_req_t l1_req_data;
	logic l1_ack;
	vc_l1_resp_t l1_resp;
	logic l2_req;
	vc_l2_req_t l2_req_data;
	logic l2_ack;
	lc3b_cache_line l2_rdata;

	integer seed = 32'hce0ef2b2;
	logic m_valid [`VC_WAYS];
	logic m_dirty [`VC_WAYS];
	lc3b_v_tag m_tag [`VC_WAYS];
	lc3b_cache_line m_line [`VC_WAYS];
	lc3b_way m_order [`VC_WAYS]; // least recent first
	lc3b_cache_line l2_shadow [0:(1<<`VC_TAG_BITS)-1];
	logic wb_seen; // the last request needed a write-back
	logic prev_ack;
	logic prev_l2_req;
	vc_l2_req_t prev_l2_data;

	victim_cache uut (.*);

	l2_memory_model l2 (.clk, .arst_n, .req(l2_req), .req_data(l2_req_data), .ack(l2_ack),
		.rdata(l2_rdata));

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic report_mismatch(input string msg);
		$display("Mismatch at %0t ns: %s", $time, msg);
		$display("TEST FAIL");
		$fatal(1);
	endtask

	task automatic abort_run(input string msg);
		$display("Error at %0t ns: %s", $time, msg);
		$display("TEST FAIL");
		$fatal(1);
	endtask

	function automatic lc3b_cache_line l2_initial_line(input lc3b_word addr);
		return {addr, ~addr, addr ^ 16'h5a5a, addr + 16'h1357,
			{addr[7:0], addr[15:8]}, addr - 16'h2468, ~addr ^ 16'h0f0f, addr ^ 16'hc3c3};
	endfunction

	function automatic lc3b_cache_line random_line();
		return {$random(seed), $random(seed), $random(seed), $random(seed)};
	endfunction

	// small pools keep tags recurring so that hits happen often
	function automatic lc3b_v_tag pick_tag(input lc3b_v_tag base);
		return base + lc3b_v_tag'({$random(seed)} % 8);
	endfunction

	function automatic logic in_model(input lc3b_v_tag t);
		for (int w = 0; w < `VC_WAYS; w++) begin
			if (m_valid[w] && m_tag[w] == t) begin
				return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	task automatic touch_model(input lc3b_way way);
		int k;
		k = 0;
		for (int i = 0; i < `VC_WAYS; i++) begin
			if (m_order[i] != way) begin
				m_order[k] = m_order[i];
				k++;
			end
		end
		m_order[`VC_WAYS-1] = way;
	endtask

	task automatic run_request(input vc_op_e op, input lc3b_v_tag tag, input lc3b_v_tag evict_tag,
			input lc3b_cache_line evict_line, input logic evict_dirty);
		logic hit;
		lc3b_way way;
		vc_l1_resp_t expect_resp;
		int base;
		int n_xfer;
		int cycles;
		hit = 1'b0;
		way = m_order[0];
		for (int w = 0; w < `VC_WAYS; w++) begin
			if (m_valid[w] && m_tag[w] == tag) begin
				hit = 1'b1;
				way = lc3b_way'(w);
			end
		end
		wb_seen = !hit && op == VC_SWAP && m_valid[way] && m_dirty[way];
		n_xfer = hit ? 0 : (wb_seen ? 2 : 1);
		expect_resp = hit ? {m_dirty[way], m_line[way]} : {1'b0, l2_shadow[tag]};
		base = l2.log_count;
		@(negedge clk);
		l1_req_data <= {op, tag, evict_tag, evict_line, evict_dirty};
		l1_req <= 1'b1;
		cycles = 0;
		while (!l1_ack) begin
			@(negedge clk);
			cycles++;
			if (cycles > 200) abort_run("l1_ack did not rise within 200 cycles of l1_req");
		end
		// the first of the counted edges is the one that samples l1_req
		if (hit) begin
			assert (cycles - 1 == 3)
				else report_mismatch($sformatf("hit on tag %h took %0d cycles", tag, cycles - 1));
		end
		assert (l1_resp == expect_resp)
			else report_mismatch($sformatf("tag %h returned %h, expected %h", tag, l1_resp,
				expect_resp));
		assert (l2.log_count - base == n_xfer)
			else report_mismatch($sformatf("tag %h made %0d L2 transactions, expected %0d", tag,
				l2.log_count - base, n_xfer));
		if (wb_seen) begin
			assert (l2.log_write[base] && l2.log_addr[base] == {m_tag[way], {`VC_OFFSET_BITS{1'b0}}}
				&& l2.log_wdata[base] == m_line[way])
				else report_mismatch($sformatf("write-back of way %0d tag %h is wrong", way,
					m_tag[way]));
			l2_shadow[m_tag[way]] = m_line[way];
		end
		if (!hit) begin
			assert (!l2.log_write[base + n_xfer - 1]
				&& l2.log_addr[base + n_xfer - 1] == {tag, {`VC_OFFSET_BITS{1'b0}}})
				else report_mismatch($sformatf("L2 read for tag %h is wrong", tag));
		end
		if (hit || op == VC_SWAP) begin
			m_valid[way] = (op == VC_SWAP); // a fetch hit hands the line back to L1
			m_tag[way] = evict_tag;
			m_line[way] = evict_line;
			m_dirty[way] = evict_dirty;
			touch_model(way);
		end
		l1_req <= 1'b0;
		cycles = 0;
		while (l1_ack) begin
			@(negedge clk);
			cycles++;
			if (cycles > 20) abort_run("l1_ack stayed high 20 cycles after l1_req dropped");
		end
	endtask

	always @(negedge clk) begin
		if (arst_n) begin
			assert (prev_ack || !l1_ack || l1_req)
				else report_mismatch("l1_ack rose while l1_req was low");
			assert (!prev_ack || l1_ack || !l1_req)
				else report_mismatch("l1_ack fell while l1_req was still high");
			assert (!(prev_l2_req && l2_req) || l2_req_data === prev_l2_data)
				else report_mismatch("l2_req_data changed while l2_req was high");
		end
		prev_ack <= l1_ack;
		prev_l2_req <= l2_req;
		prev_l2_data <= l2_req_data;
	end

	initial begin : stimulus
		lc3b_v_tag tag;
		lc3b_v_tag evict;
		arst_n = 1'b0;
		l1_req = 1'b0;
		l1_req_data = '0;
		for (int w = 0; w < `VC_WAYS; w++) begin
			m_valid[w] = 1'b0;
			m_order[w] = lc3b_way'(w);
		end
		for (int t = 0; t < (1 << `VC_TAG_BITS); t++) begin
			l2_shadow[t] = l2_initial_line({lc3b_v_tag'(t), {`VC_OFFSET_BITS{1'b0}}});
		end
		repeat (3) @(posedge clk);
		@(negedge clk);
		arst_n <= 1'b1;
		@(negedge clk);
		assert (!l1_ack && !l2_req) else report_mismatch("l1_ack or l2_req high after reset");
		run_request(VC_FETCH, pick_tag(12'h0a0), '0, '0, 1'b0);
		// swap in a dirty line and get it back as a hit
		evict = pick_tag(12'h100);
		run_request(VC_SWAP, pick_tag(12'h200), evict, random_line(), 1'b1);
		run_request(VC_FETCH, evict, '0, '0, 1'b0);
		for (int i = 0; i < 5; i++) begin
			run_request(VC_SWAP, 12'h500 + 12'(i), 12'h400 + 12'(i), random_line(), 1'b1);
		end
		// refreshing the oldest way makes the next miss evict the one after it
		run_request(VC_SWAP, m_tag[m_order[0]], 12'h410, random_line(), 1'b1);
		run_request(VC_SWAP, 12'h520, 12'h411, random_line(), 1'b1);
		run_request(VC_FETCH, 12'h410, '0, '0, 1'b0);
		for (int i = 0; i < 60; i++) begin
			tag = pick_tag(12'h300);
			evict = pick_tag(12'h300);
			for (int k = 0; k < 8 && (evict == tag || in_model(evict)); k++) begin
				evict = 12'h300 | ((evict + 12'd1) & 12'h007);
			end
			run_request((($random(seed) & 1) != 0) ? VC_SWAP : VC_FETCH, tag, evict,
				random_line(), (($random(seed) & 1) != 0));
		end
		$display("TEST PASS");
		$finish;
	end

endmodule : victim_cache_tb

// File: project.f
+incdir+hdl
hdl/lc3b_types.sv
hdl/cache_slot.sv
hdl/victim_fill_stage.sv
hdl/victim_drain_stage.sv
hdl/victim_lru.sv
hdl/victim_cache_control.sv
hdl/victim_cache.sv
tb/l2_memory_model.sv
tb/victim_cache_tb.sv

// File: Bender.yml
package:
  name: victim_cache

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/lc3b_types.sv
      - hdl/cache_slot.sv
      - hdl/victim_fill_stage.sv
      - hdl/victim_drain_stage.sv
      - hdl/victim_lru.sv
      - hdl/victim_cache_control.sv
      - hdl/victim_cache.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tb/l2_memory_model.sv
      - tb/victim_cache_tb.sv
